// ==== rtl/ddr_test_pkg.sv ====
/*
 * Shared widths, types and constants for the DDR3 local-port traffic
 * generator. Every RTL block imports what it needs from here.
 */

package ddr_test_pkg;

  // --------------------------------------------------
  // local port geometry
  // --------------------------------------------------
  localparam int NUM_LANES = 8;

  typedef logic [8*NUM_LANES-1:0] data_t;
  typedef logic [7:0]             lane_t;
  typedef logic [NUM_LANES-1:0]   lane_mask_t;
  typedef logic [12:0]            row_t;
  typedef logic [9:0]             col_t;
  typedef logic [2:0]             bank_t;
  typedef logic [7:0]             beats_t;
  typedef logic [7:0]             status_t;

  // beats per burst, fixed by the attached memory
  localparam beats_t BURST_LEN = 8'd2;

  // column advance for one burst of full-rate beats
  localparam col_t COL_STEP = 10'd8;

  // power-up value of each byte-lane LFSR, lane 0 first
  localparam lane_t LANE_SEED [NUM_LANES] = '{
    8'd1, 8'd11, 8'd21, 8'd31, 8'd41, 8'd51, 8'd61, 8'd71
  };

  // --------------------------------------------------
  // pass sequencing FSM
  // --------------------------------------------------
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_WR_FIRST,
    ST_WR_NEXT,
    ST_RELOAD,
    ST_READ,
    ST_READ_WAIT,
    ST_DONE
  } ctrl_state_e;

endpackage

// ==== rtl/lfsr8.sv ====
/*
 * One 8-bit byte-lane LFSR. Steps once per cycle while enabled and not
 * paused; a load overrides the step and takes ldata on the next edge.
 */

module lfsr8 import ddr_test_pkg::*; #(
  parameter lane_t SEED = 8'd1
) (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  enable,
  input  logic  pause,
  input  logic  load,
  input  lane_t ldata,
  output lane_t data
);

  lane_t lfsr_q;
  logic  feedback;

  // taps 7, 5, 4, 3 give a maximal-length sequence
  assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      lfsr_q <= SEED;
    end
    else if (load)
    begin
      lfsr_q <= ldata;
    end
    else if (enable && !pause)
    begin
      lfsr_q <= {lfsr_q[6:0], feedback};
    end
  end

  assign data = lfsr_q;

endmodule

// ==== rtl/data_gen.sv ====
/*
 * 64-bit pseudo-random pattern built from eight LFSR lanes. The pattern
 * at the start of a pass is kept so the read phase can replay it.
 */

module data_gen import ddr_test_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  advance,
  input  logic  capture,
  input  logic  reload,
  output data_t data
);

  data_t pattern;
  data_t start_pattern;
  logic  lane_pause;

  // lanes always enabled, the step is gated by pause alone
  assign lane_pause = ~advance;

  // --------------------------------------------------
  // byte lanes
  // --------------------------------------------------
  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_lane
    lfsr8 #(
      .SEED (LANE_SEED[i])
    ) u_lfsr (
      .clk     (clk),
      .reset_n (reset_n),
      .enable  (1'b1),
      .pause   (lane_pause),
      .load    (reload),
      .ldata   (start_pattern[8*i +: 8]),
      .data    (pattern[8*i +: 8])
    );
  end

  // pattern seen before the first write beat of the pass
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      start_pattern <= pattern;
    end
  end

  assign data = pattern;

endmodule

// ==== rtl/addr_gen.sv ====
/*
 * Burst address counters for the two test passes. Sequential mode counts
 * column, row then bank; walking mode sends one hot bit over row and column.
 */

module addr_gen import ddr_test_pkg::*; #(
  parameter row_t  MAX_ROW  = 13'd3,
  parameter col_t  MAX_COL  = 10'd16,
  parameter bank_t MAX_BANK = 3'd7
) (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  step,
  input  logic  clear,
  input  logic  walk_mode,
  output row_t  row,
  output col_t  col,
  output bank_t bank,
  output logic  last_addr
);

  logic seq_last;
  logic walk_last;

  assign seq_last  = (col == MAX_COL) && (row == MAX_ROW) && (bank == MAX_BANK);
  assign walk_last = &row;
  assign last_addr = walk_mode ? walk_last : seq_last;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      row  <= '0;
      col  <= '0;
      bank <= '0;
    end
    else if (clear)
    begin
      row  <= '0;
      col  <= '0;
      bank <= '0;
    end
    else if (step && walk_mode)
    begin
      // --------------------------------------------------
      // walking pass
      // --------------------------------------------------
      if (row == '0)
      begin
        row <= 13'd1;
        col <= 10'd8;
      end
      else if (row[12])
      begin
        // top bit reached, finish on all ones
        row <= '1;
        col <= {7'h7f, 3'b000};
      end
      else
      begin
        row        <= {row[11:0], row[12]};
        col[9:3]   <= {col[8:3], col[9]};
      end
      bank <= (bank == MAX_BANK) ? '0 : bank + 3'd1;
    end
    else if (step)
    begin
      // --------------------------------------------------
      // sequential pass
      // --------------------------------------------------
      if (col == MAX_COL)
      begin
        col <= '0;
        if (row == MAX_ROW)
        begin
          row  <= '0;
          bank <= (bank == MAX_BANK) ? '0 : bank + 3'd1;
        end
        else
        begin
          row <= row + 13'd1;
        end
      end
      else
      begin
        col <= col + COL_STEP;
      end
    end
  end

endmodule

// ==== rtl/read_checker.sv ====
/*
 * Compares returned read data with the regenerated pattern per byte lane.
 * Results appear three cycles after the beat, the sticky flag one later.
 */

module read_checker import ddr_test_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  data_t      rdata,
  input  logic       rdata_valid,
  input  data_t      expected,
  output lane_mask_t pnf_per_byte,
  output logic       pnf_persist
);

  lane_mask_t lane_match;
  lane_mask_t match_q;
  lane_mask_t valid_match;
  lane_mask_t valid_match_q;
  logic       valid_q;
  logic       seen_read;
  logic       seen_read_d1;
  logic       seen_read_d2;
  logic       pass_q;
  logic       pass_prev;

  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_cmp
    assign lane_match[i] = (rdata[8*i +: 8] == expected[8*i +: 8]);
  end

  // before the first checked beat there is no history to hold against
  assign pass_prev = seen_read_d2 ? pass_q : 1'b1;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      match_q       <= '1;
      valid_match   <= '1;
      valid_match_q <= '1;
      valid_q       <= 1'b0;
      seen_read     <= 1'b0;
      seen_read_d1  <= 1'b0;
      seen_read_d2  <= 1'b0;
      pass_q        <= 1'b0;
      pnf_persist   <= 1'b0;
    end
    else
    begin
      match_q <= lane_match;
      valid_q <= rdata_valid;
      if (rdata_valid)
      begin
        seen_read <= 1'b1;
      end
      seen_read_d1 <= seen_read;
      seen_read_d2 <= seen_read_d1;

      // only a compare from a valid beat is kept
      if (valid_q)
      begin
        valid_match <= match_q;
      end
      valid_match_q <= valid_match;

      pass_q      <= (&valid_match) && seen_read_d1 && pass_prev;
      pnf_persist <= pass_q;
    end
  end

  assign pnf_per_byte = valid_match_q;

endmodule

// ==== rtl/test_ctrl.sv ====
/*
 * Pass sequencer. Runs a sequential then a walking pass of burst writes
 * followed by read-back, then pulses test_complete and starts over.
 */

module test_ctrl import ddr_test_pkg::*; (
  input  logic clk,
  input  logic reset_n,
  input  logic ready,
  input  logic rdata_valid,
  input  logic last_addr,
  output logic write_req,
  output logic read_req,
  output logic burst_begin,
  output logic addr_step,
  output logic addr_clear,
  output logic walk_mode,
  output logic capture,
  output logic reload,
  output logic beat_done,
  output logic seq_mode,
  output logic test_complete
);

  ctrl_state_e state;
  beats_t      beat_cnt;
  beats_t      reads_out;
  logic        final_burst;
  logic        seq_done;
  logic        write_acc;
  logic        read_acc;

  assign write_acc = write_req & ready;
  assign read_acc  = read_req & ready;
  assign beat_done = write_acc;
  // address moves on the first beat of a write burst or on a read command
  assign addr_step = (write_acc & burst_begin) | read_acc;

  // --------------------------------------------------
  // read beats still owed by the memory
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      reads_out <= '0;
    else if (read_acc && !rdata_valid)
      reads_out <= reads_out + BURST_LEN;
    else if (read_acc && rdata_valid)
      reads_out <= reads_out + BURST_LEN - 8'd1;
    else if (rdata_valid && reads_out != '0)
      reads_out <= reads_out - 8'd1;
  end

  // --------------------------------------------------
  // pass state machine
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= ST_IDLE;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      burst_begin   <= 1'b0;
      addr_clear    <= 1'b0;
      capture       <= 1'b0;
      reload        <= 1'b0;
      test_complete <= 1'b0;
      seq_mode      <= 1'b0;
      walk_mode     <= 1'b0;
      seq_done      <= 1'b0;
      final_burst   <= 1'b0;
      beat_cnt      <= '0;
    end
    else
    begin
      // single-cycle strobes
      addr_clear    <= 1'b0;
      capture       <= 1'b0;
      reload        <= 1'b0;
      test_complete <= 1'b0;
      case (state)
        ST_IDLE:
          state <= ST_SETUP;
        ST_SETUP:
        begin
          seq_mode    <= ~seq_done;
          walk_mode   <= seq_done;
          capture     <= 1'b1;
          write_req   <= 1'b1;
          burst_begin <= 1'b1;
          state       <= ST_WR_FIRST;
        end
        ST_WR_FIRST:
          if (write_acc)
          begin
            final_burst <= last_addr;
            burst_begin <= 1'b0;
            beat_cnt    <= 8'd1;
            state       <= ST_WR_NEXT;
          end
        ST_WR_NEXT:
          if (write_acc && beat_cnt == BURST_LEN - 8'd1)
          begin
            beat_cnt <= '0;
            if (final_burst)
            begin
              write_req  <= 1'b0;
              addr_clear <= 1'b1;
              reload     <= 1'b1;
              state      <= ST_RELOAD;
            end
            else
            begin
              burst_begin <= 1'b1;
              state       <= ST_WR_FIRST;
            end
          end
          else if (write_acc)
            beat_cnt <= beat_cnt + 8'd1;
        ST_RELOAD:
        begin
          read_req    <= 1'b1;
          burst_begin <= 1'b1;
          state       <= ST_READ;
        end
        ST_READ:
          if (read_acc && last_addr)
          begin
            read_req    <= 1'b0;
            burst_begin <= 1'b0;
            state       <= ST_READ_WAIT;
          end
        ST_READ_WAIT:
          if (reads_out == '0)
          begin
            addr_clear <= 1'b1;
            seq_mode   <= 1'b0;
            walk_mode  <= 1'b0;
            seq_done   <= ~seq_done;
            if (seq_mode)
              state <= ST_SETUP;
            else
            begin
              test_complete <= 1'b1;
              state         <= ST_DONE;
            end
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/ddr_example_driver.sv ====
/*
 * DDR3 local-port traffic generator and checker. Writes an LFSR pattern,
 * reads it back and reports per-byte and sticky pass flags.
 */

module ddr_example_driver import ddr_test_pkg::*; #(
  parameter row_t  MAX_ROW  = 13'd3,
  parameter col_t  MAX_COL  = 10'd16,
  parameter bank_t MAX_BANK = 3'd7
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       local_ready,
  input  data_t      local_rdata,
  input  logic       local_rdata_valid,
  output logic       local_write_req,
  output logic       local_read_req,
  output logic       local_burstbegin,
  output row_t       local_row_addr,
  output col_t       local_col_addr,
  output bank_t      local_bank_addr,
  output data_t      local_wdata,
  output lane_mask_t pnf_per_byte,
  output logic       pnf_persist,
  output logic       test_complete,
  output status_t    test_status
);

  logic  addr_step;
  logic  addr_clear;
  logic  walk_mode;
  logic  seq_mode;
  logic  last_addr;
  logic  capture;
  logic  reload;
  logic  beat_done;
  logic  dgen_advance;
  data_t pattern;

  // one LFSR step per written or returned beat
  assign dgen_advance = beat_done | local_rdata_valid;
  assign local_wdata  = pattern;
  assign test_status  = {test_complete, 3'b000, walk_mode, 2'b00, seq_mode};

  test_ctrl u_ctrl (
    .clk (clk), .reset_n (reset_n), .ready (local_ready),
    .rdata_valid (local_rdata_valid), .last_addr (last_addr),
    .write_req (local_write_req), .read_req (local_read_req),
    .burst_begin (local_burstbegin), .addr_step (addr_step), .addr_clear (addr_clear),
    .walk_mode (walk_mode), .capture (capture), .reload (reload),
    .beat_done (beat_done), .seq_mode (seq_mode), .test_complete (test_complete)
  );

  addr_gen #(.MAX_ROW (MAX_ROW), .MAX_COL (MAX_COL), .MAX_BANK (MAX_BANK)) u_addr (
    .clk (clk), .reset_n (reset_n), .step (addr_step), .clear (addr_clear),
    .walk_mode (walk_mode), .row (local_row_addr), .col (local_col_addr),
    .bank (local_bank_addr), .last_addr (last_addr)
  );

  data_gen u_dgen (
    .clk (clk), .reset_n (reset_n), .advance (dgen_advance),
    .capture (capture), .reload (reload), .data (pattern)
  );

  read_checker u_check (
    .clk (clk), .reset_n (reset_n), .rdata (local_rdata),
    .rdata_valid (local_rdata_valid), .expected (pattern),
    .pnf_per_byte (pnf_per_byte), .pnf_persist (pnf_persist)
  );

endmodule

// ==== sim/driver_props.sv ====
/*
 * Concurrent checks on the local-port request signals and test_complete,
 * bound into the top level of the traffic generator.
 */

module driver_props (
  input logic clk,
  input logic reset_n,
  input logic write_req,
  input logic read_req,
  input logic burst_begin,
  input logic test_complete
);

  a_one_request: assert property (@(posedge clk) disable iff (!reset_n)
    !(write_req && read_req))
    else $error("write and read requests high together");

  a_begin_with_req: assert property (@(posedge clk) disable iff (!reset_n)
    burst_begin |-> (write_req || read_req))
    else $error("burstbegin without a request");

  a_complete_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    test_complete |=> !test_complete)
    else $error("test_complete high for two cycles");

endmodule

bind ddr_example_driver driver_props u_props (
  .clk (clk), .reset_n (reset_n), .write_req (local_write_req),
  .read_req (local_read_req), .burst_begin (local_burstbegin),
  .test_complete (test_complete)
);

// ==== sim/tb_driver.sv ====
/*
 * Testbench for the DDR3 traffic generator. Models the controller local port
 * with a random ready and a burst memory, and checks addresses, data and flags.
 */

module tb_driver;
  import ddr_test_pkg::*;

  localparam int SEQ_BURSTS  = 96;
  localparam int WALK_BURSTS = 15;
  localparam int RUNS        = 3;
  // one run: write beats, read commands and read beats at three quarters ready
  localparam int RUN_EST     = ((SEQ_BURSTS + WALK_BURSTS) * 5 * 4) / 3 + 100;
  localparam int CYCLE_LIMIT = 4 * 2 * RUN_EST;

  logic clk = 1'b0;
  logic reset_n;
  logic local_ready;
  data_t local_rdata;
  logic local_rdata_valid;
  logic local_write_req, local_read_req, local_burstbegin;
  row_t local_row_addr;
  col_t local_col_addr;
  bank_t local_bank_addr;
  data_t local_wdata;
  lane_mask_t pnf_per_byte;
  logic pnf_persist, test_complete;
  status_t test_status;

  data_t mem [logic [26:0]];
  logic [25:0] rd_base_q [$];
  int rd_due_q [$];
  logic [25:0] rd_base, wr_base;
  lane_t lanes [NUM_LANES];
  lane_t saved [NUM_LANES];
  int cyc = 0, errors = 0, writes = 0, reads = 0, run_count = 0;
  int pass_idx = 0, bursts = 0, wbeat = 0, rd_left = 0, next_free = 0, check_at = -1;
  int rd_lat;
  bit rd_phase = 0, fault_done = 0, lane5_low = 0, persist_fell = 0, end_run = 0;

  ddr_example_driver uut (.*);

  always #50 clk = ~clk;

  // reference lane step: shift left, new low bit from taps 7, 5, 4, 3
  function automatic lane_t lfsr_next(lane_t v);
    return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
  endfunction

  function automatic data_t model_word();
    data_t w;
    for (int i = 0; i < NUM_LANES; i++)
      w[8*i +: 8] = lanes[i];
    return w;
  endfunction

  task automatic step_lanes();
    for (int i = 0; i < NUM_LANES; i++)
      lanes[i] = lfsr_next(lanes[i]);
  endtask

  // burst k of a pass as {bank, row, col}
  function automatic logic [25:0] expected_addr(int pass, int k);
    row_t r;
    col_t c;
    bank_t b;
    if (pass == 0)
    begin
      c = col_t'((k % 3) * 8);
      r = row_t'((k / 3) % 4);
      b = bank_t'(k / 12);
    end
    else
    begin
      b = bank_t'(k % 8);
      if (k == 0)
        {r, c} = '0;
      else if (k == WALK_BURSTS - 1)
        {r, c} = {13'h1fff, 10'h3f8};
      else
        {r, c} = {row_t'(1) << (k - 1), col_t'(8) << ((k - 1) % 7)};
    end
    return {b, r, c};
  endfunction

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    if (exp !== act)
    begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_command(string kind, int nbeat);
    check_value({kind, " burstbegin"}, 64'(nbeat == 0), 64'(local_burstbegin));
    if (nbeat == 0)
    begin
      check_value({kind, " address"}, 64'(expected_addr(pass_idx, bursts)),
                  64'({local_bank_addr, local_row_addr, local_col_addr}));
      check_value({kind, " status"}, (pass_idx == 0) ? 64'h01 : 64'h08,
                  64'(test_status));
    end
  endtask

  initial
  begin
    void'($urandom(32'h6447));
    reset_n = 1'b0;
    local_ready = 1'b0;
    local_rdata = '0;
    local_rdata_valid = 1'b0;
    for (int i = 0; i < NUM_LANES; i++)
      lanes[i] = LANE_SEED[i];
    repeat (4) @(posedge clk);
    #10 reset_n = 1'b1;
  end

  // --------------------------------------------------
  // memory side: ready and read bursts
  // --------------------------------------------------
  always @(posedge clk)
  begin
    cyc++;
    if (cyc > CYCLE_LIMIT && !end_run)
    begin
      errors++;
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      end_run = 1;
    end
    #10;
    local_ready = ($urandom % 4) != 0;
    local_rdata_valid = 1'b0;
    if (rd_left == 0 && rd_due_q.size() > 0 && rd_due_q[0] <= cyc)
    begin
      void'(rd_due_q.pop_front());
      rd_base = rd_base_q.pop_front();
      rd_left = BURST_LEN;
    end
    if (rd_left > 0)
    begin
      local_rdata = mem.exists({rd_base, 1'(BURST_LEN - rd_left)}) ?
                    mem[{rd_base, 1'(BURST_LEN - rd_left)}] : '0;
      // one flipped bit in lane 5 during the third run
      if (run_count == 2 && !fault_done)
      begin
        local_rdata[41] = ~local_rdata[41];
        fault_done = 1;
      end
      local_rdata_valid = 1'b1;
      rd_left--;
    end
  end

  // --------------------------------------------------
  // monitor and checks, sampled mid-cycle
  // --------------------------------------------------
  always @(negedge clk)
  begin
    if (reset_n && !end_run)
    begin
      if (local_write_req && local_ready)
      begin
        check_command("write", wbeat);
        if (rd_phase)
        begin
          errors++;
          $display("write beat accepted during the read phase");
        end
        if (wbeat == 0)
          wr_base = {local_bank_addr, local_row_addr, local_col_addr};
        if (wbeat == 0 && bursts == 0)
          saved = lanes;
        check_value("write data", model_word(), local_wdata);
        mem[{wr_base, 1'(wbeat)}] = local_wdata;
        step_lanes();
        writes++;
        wbeat++;
        if (wbeat == BURST_LEN)
        begin
          wbeat = 0;
          bursts++;
          if (bursts == ((pass_idx == 0) ? SEQ_BURSTS : WALK_BURSTS))
          begin
            bursts = 0;
            rd_phase = 1;
          end
        end
      end
      if (local_read_req && local_ready)
      begin
        if (!rd_phase)
        begin
          errors++;
          $display("read command accepted during the write phase");
        end
        if (bursts == 0)
          lanes = saved;
        check_command("read", 0);
        rd_base_q.push_back({local_bank_addr, local_row_addr, local_col_addr});
        rd_lat = 2 + int'($urandom % 4);
        next_free = (cyc + rd_lat > next_free) ? cyc + rd_lat : next_free;
        rd_due_q.push_back(next_free);
        next_free += BURST_LEN;
        reads++;
        bursts++;
        if (bursts == ((pass_idx == 0) ? SEQ_BURSTS : WALK_BURSTS))
        begin
          bursts = 0;
          rd_phase = 0;
          pass_idx ^= 1;
        end
      end
      if (local_rdata_valid)
        step_lanes();
      if (!pnf_per_byte[5])
        lane5_low = 1;
      if (persist_fell && pnf_persist)
      begin
        errors++;
        $display("pnf_persist rose again after a failed beat");
      end
      if (run_count == 2 && !pnf_persist && fault_done)
        persist_fell = 1;
      if (test_complete)
      begin
        check_value("test_status at completion", 64'h80, 64'(test_status));
        if (pass_idx != 0 || rd_phase || bursts != 0)
        begin
          errors++;
          $display("test_complete pulsed before both passes finished");
        end
        run_count++;
        check_at = cyc + 5;
      end
      if (cyc == check_at && run_count == 2)
      begin
        check_value("clean pnf_persist", 64'h1, 64'(pnf_persist));
        check_value("clean pnf_per_byte", 64'hff, 64'(pnf_per_byte));
      end
      if (cyc == check_at && run_count == RUNS)
      begin
        check_value("fault pnf_persist", 64'h0, 64'(pnf_persist));
        check_value("fault lane 5 seen low", 64'h1, 64'(lane5_low));
        end_run = 1;
      end
    end
  end

  initial
  begin
    wait (end_run);
    $display("errors %0d, write beats %0d, read commands %0d, runs %0d",
             errors, writes, reads, run_count);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== tb.f ====
rtl/ddr_test_pkg.sv
rtl/lfsr8.sv
rtl/data_gen.sv
rtl/addr_gen.sv
rtl/read_checker.sv
rtl/test_ctrl.sv
rtl/ddr_example_driver.sv
sim/driver_props.sv
sim/tb_driver.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then search the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_driver -f tb.f -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1
grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Regression passed" sim.log || { echo "FAIL: no result in sim.log"; exit 1; }
echo "PASS"
exit 0
